/* Bender.yml */
package:
  name: lc4_superscalar

sources:
  - hdl/lc4_pkg.sv
  - hdl/lc4_alu.sv
  - hdl/lc4_decoder.sv
  - hdl/lc4_regfile_2w.sv
  - hdl/lc4_fetch_issue.sv
  - hdl/lc4_execute.sv
  - hdl/lc4_superscalar.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_lc4_superscalar.sv

/* include/tb_lc4_model.svh */
`ifndef TB_LC4_MODEL_SVH
`define TB_LC4_MODEL_SVH

// one retired instruction as the writeback trace shows it
typedef struct packed {
   lc4_pkg::word_t    pc;
   lc4_pkg::word_t    insn;
   logic              we;
   lc4_pkg::reg_idx_t wsel;
   lc4_pkg::word_t    data;
} exp_entry_t;

typedef lc4_pkg::word_t prog_t[$];
typedef exp_entry_t     exp_list_t[$];

// program image encoders
function automatic lc4_pkg::word_t enc_rrr(logic [3:0] opc, logic [2:0] sub,
                                           lc4_pkg::reg_idx_t rd, rs, rt);
   return {opc, rd, rs, sub, rt};
endfunction

function automatic lc4_pkg::word_t enc_addi(lc4_pkg::reg_idx_t rd, rs, logic [4:0] imm);
   return {lc4_pkg::OPC_ARITH, rd, rs, 1'b1, imm};
endfunction

function automatic lc4_pkg::word_t enc_const(lc4_pkg::reg_idx_t rd, logic [8:0] imm);
   return {lc4_pkg::OPC_CONST, rd, imm};
endfunction

function automatic lc4_pkg::word_t enc_nop();
   return {lc4_pkg::OPC_NOP, 12'h000};
endfunction

// Runs the program in order from RESET_PC; rf carries register state across calls.
function automatic exp_list_t model_run(prog_t prog, inout lc4_pkg::word_t rf[lc4_pkg::NUM_REGS]);
   exp_list_t      q;
   exp_entry_t     e;
   lc4_pkg::word_t a, b;
   logic [2:0]     sub;
   foreach (prog[i]) begin
      a      = rf[prog[i][8:6]];
      b      = rf[prog[i][2:0]];
      sub    = prog[i][5:3];
      e.pc   = lc4_pkg::RESET_PC + 16'(i);
      e.insn = prog[i];
      e.wsel = prog[i][11:9];
      e.we   = 1'b1;
      e.data = '0;
      case (prog[i][15:12])
         lc4_pkg::OPC_ARITH:
            if (sub[2])
               e.data = a + {{11{prog[i][4]}}, prog[i][4:0]};
            else if (sub == lc4_pkg::SUB_ADD)
               e.data = a + b;
            else if (sub == lc4_pkg::SUB_SUB)
               e.data = a - b;
            else
               e.we = 1'b0;
         lc4_pkg::OPC_LOGIC:
            if (sub == lc4_pkg::SUB_AND)
               e.data = a & b;
            else if (sub == lc4_pkg::SUB_OR)
               e.data = a | b;
            else if (sub == lc4_pkg::SUB_XOR)
               e.data = a ^ b;
            else
               e.we = 1'b0;
         lc4_pkg::OPC_CONST:
            e.data = {{7{prog[i][8]}}, prog[i][8:0]};
         default:
            e.we = 1'b0;
      endcase
      if (e.we)
         rf[e.wsel] = e.data;
      q.push_back(e);
   end
   return q;
endfunction

`endif

/* bench/tb_lc4_superscalar.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lc4_superscalar;

   `include "tb_lc4_model.svh"

   localparam int DRIVE_DLY = 2;

   logic              gwe = 1'b0;
   logic              arst_n;
   lc4_pkg::word_t    insn_a, insn_b;
   lc4_pkg::word_t    cur_pc;
   lc4_pkg::word_t    wb_pc_a, wb_pc_b, wb_insn_a, wb_insn_b;
   logic              wb_we_a, wb_we_b;
   lc4_pkg::reg_idx_t wb_wsel_a, wb_wsel_b;
   lc4_pkg::word_t    wb_data_a, wb_data_b;
   lc4_pkg::stall_e   wb_stall_a, wb_stall_b;

   // instruction image and expected retirement list of the running program
   prog_t       imem;
   exp_list_t   exp_q;
   int          exp_idx;
   int          ss_count;
   logic        seen_retire;
   logic [31:0] lfsr_state = 32'hd92928ef;

   lc4_superscalar u_lc4_superscalar (
      .gwe(gwe), .i_arst_n(arst_n), .o_cur_pc(cur_pc),
      .i_insn_a(insn_a), .i_insn_b(insn_b),
      .o_wb_pc_a(wb_pc_a), .o_wb_pc_b(wb_pc_b),
      .o_wb_insn_a(wb_insn_a), .o_wb_insn_b(wb_insn_b),
      .o_wb_we_a(wb_we_a), .o_wb_we_b(wb_we_b),
      .o_wb_wsel_a(wb_wsel_a), .o_wb_wsel_b(wb_wsel_b),
      .o_wb_data_a(wb_data_a), .o_wb_data_b(wb_data_b),
      .o_wb_stall_a(wb_stall_a), .o_wb_stall_b(wb_stall_b)
   );

   initial begin
      forever #20 gwe = ~gwe;
   end

   task automatic abort(string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_val(string name, logic [15:0] got, logic [15:0] want);
      if (got !== want)
         abort($sformatf("FAIL %s: got %h, expected %h", name, got, want));
   endtask

   // 32-bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r          = {r[14:0], fb};
      end
      return r;
   endfunction

   function automatic lc4_pkg::word_t fetch_word(lc4_pkg::word_t addr);
      lc4_pkg::word_t idx;
      idx = addr - lc4_pkg::RESET_PC;
      if (int'(idx) < imem.size())
         return imem[idx];
      return '0;
   endfunction

   function automatic prog_t directed_prog();
      prog_t p;
      p.push_back(enc_const(3'd1, 9'h005));
      p.push_back(enc_const(3'd2, 9'h1fd));
      // reads both W slots of the pair ahead
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_ADD, 3'd3, 3'd1, 3'd2));
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_SUB, 3'd4, 3'd2, 3'd1));
      // B reads A's destination
      p.push_back(enc_addi(3'd5, 3'd3, 5'h07));
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_ADD, 3'd6, 3'd5, 3'd4));
      p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_AND, 3'd7, 3'd1, 3'd2));
      p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_OR, 3'd0, 3'd6, 3'd7));
      p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_XOR, 3'd1, 3'd3, 3'd4));
      // same destination in one pair followed by a reader
      p.push_back(enc_const(3'd3, 9'h011));
      p.push_back(enc_const(3'd3, 9'h022));
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_ADD, 3'd4, 3'd3, 3'd3));
      p.push_back(enc_addi(3'd5, 3'd3, 5'h01));
      p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_XOR, 3'd6, 3'd3, 3'd4));
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_ADD, 3'd7, 3'd6, 3'd6));
      p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_SUB, 3'd0, 3'd7, 3'd5));
      p.push_back(enc_nop());
      p.push_back(enc_addi(3'd1, 3'd1, 5'h1f));
      return p;
   endfunction

   function automatic prog_t random_prog(int n);
      prog_t      p;
      logic [2:0] kind, rd, rs, rt;
      for (int i = 0; i < n; i++) begin
         kind = 3'(rand_bits(3));
         rd   = 3'(rand_bits(3));
         rs   = 3'(rand_bits(3));
         rt   = 3'(rand_bits(3));
         case (kind)
            3'd0: p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_ADD, rd, rs, rt));
            3'd1: p.push_back(enc_rrr(lc4_pkg::OPC_ARITH, lc4_pkg::SUB_SUB, rd, rs, rt));
            3'd2: p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_AND, rd, rs, rt));
            3'd3: p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_OR, rd, rs, rt));
            3'd4: p.push_back(enc_rrr(lc4_pkg::OPC_LOGIC, lc4_pkg::SUB_XOR, rd, rs, rt));
            3'd5: p.push_back(enc_addi(rd, rs, 5'(rand_bits(5))));
            3'd6: p.push_back(enc_const(rd, 9'(rand_bits(9))));
            default: p.push_back(enc_nop());
         endcase
      end
      return p;
   endfunction

   // instruction memory answers a short delay after each edge
   always @(posedge gwe) begin
      #DRIVE_DLY;
      insn_a = fetch_word(cur_pc);
      insn_b = fetch_word(cur_pc + 16'd1);
   end

   task automatic retire_slot(string slot, lc4_pkg::stall_e stall, lc4_pkg::word_t pc,
                              lc4_pkg::word_t insn, logic we, lc4_pkg::reg_idx_t wsel,
                              lc4_pkg::word_t data);
      exp_entry_t e;
      if (stall != lc4_pkg::STALL_NONE)
         return;
      // past the end only zero words may retire
      if (exp_idx >= exp_q.size()) begin
         check_val({"o_wb_insn_", slot}, insn, 16'h0000);
         check_val({"o_wb_we_", slot}, 16'(we), 16'h0000);
         return;
      end
      e = exp_q[exp_idx];
      check_val({"o_wb_pc_", slot}, pc, e.pc);
      check_val({"o_wb_insn_", slot}, insn, e.insn);
      check_val({"o_wb_we_", slot}, 16'(we), 16'(e.we));
      check_val({"o_wb_wsel_", slot}, 16'(wsel), 16'(e.wsel));
      check_val({"o_wb_data_", slot}, data, e.data);
      exp_idx++;
   endtask

   // sampled mid-cycle with slot a older than slot b
   always @(negedge gwe) begin
      if (!seen_retire) begin
         if (wb_stall_a == lc4_pkg::STALL_NONE) begin
            seen_retire = 1'b1;
         end else begin
            check_val("o_wb_stall_a", 16'(wb_stall_a), 16'(lc4_pkg::STALL_EMPTY));
            check_val("o_wb_stall_b", 16'(wb_stall_b), 16'(lc4_pkg::STALL_EMPTY));
            check_val("o_wb_we_a", 16'(wb_we_a), 16'h0000);
            check_val("o_wb_we_b", 16'(wb_we_b), 16'h0000);
         end
      end
      if (wb_stall_b == lc4_pkg::STALL_SS)
         ss_count++;
      retire_slot("a", wb_stall_a, wb_pc_a, wb_insn_a, wb_we_a, wb_wsel_a, wb_data_a);
      retire_slot("b", wb_stall_b, wb_pc_b, wb_insn_b, wb_we_b, wb_wsel_b, wb_data_b);
   end

   task automatic run_program(prog_t prog, int min_ss);
      lc4_pkg::word_t rf [lc4_pkg::NUM_REGS];
      int             cycles;
      @(posedge gwe);
      #DRIVE_DLY;
      arst_n = 1'b0;
      // register file comes out of reset cleared
      foreach (rf[i])
         rf[i] = '0;
      imem        = prog;
      exp_q       = model_run(prog, rf);
      exp_idx     = 0;
      ss_count    = 0;
      seen_retire = 1'b0;
      repeat (2) @(posedge gwe);
      #DRIVE_DLY;
      check_val("o_cur_pc", cur_pc, lc4_pkg::RESET_PC);
      arst_n = 1'b1;
      cycles = 0;
      while (exp_idx < exp_q.size()) begin
         @(posedge gwe);
         cycles++;
         if (cycles > 4 * prog.size() + 20)
            abort($sformatf("timeout: only %0d of %0d instructions retired",
                            exp_idx, exp_q.size()));
      end
      if (ss_count < min_ss)
         abort("no dependence bubble appeared in slot b");
   endtask

   initial begin
      arst_n      = 1'b0;
      insn_a      = '0;
      insn_b      = '0;
      exp_idx     = 0;
      ss_count    = 0;
      seen_retire = 1'b0;
      run_program(directed_prog(), 1);
      run_program(random_prog(240), 1);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/lc4_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_alu (
   input  wire lc4_pkg::alu_op_e i_op,
   input  wire lc4_pkg::word_t   i_a, i_b, i_imm,
   input  wire                   i_use_imm,
   output lc4_pkg::word_t        o_result
);

   lc4_pkg::word_t opnd_b;

   assign opnd_b = i_use_imm ? i_imm : i_b;

   always_comb begin
      case (i_op)
         lc4_pkg::ALU_ADD:  o_result = i_a + opnd_b;
         lc4_pkg::ALU_SUB:  o_result = i_a - opnd_b;
         lc4_pkg::ALU_AND:  o_result = i_a & opnd_b;
         lc4_pkg::ALU_OR:   o_result = i_a | opnd_b;
         lc4_pkg::ALU_XOR:  o_result = i_a ^ opnd_b;
         // CONST, and the zero result of a NOP
         lc4_pkg::ALU_PASS: o_result = i_imm;
         default:           o_result = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/lc4_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_decoder (
   input  wire lc4_pkg::word_t i_insn,
   output lc4_pkg::reg_idx_t   o_rs, o_rt, o_rd,
   output logic                o_rs_re, o_rt_re, o_we,
   output lc4_pkg::alu_op_e    o_op,
   output lc4_pkg::word_t      o_imm
);

   logic [2:0] sub;

   assign sub  = i_insn[5:3];
   assign o_rd = i_insn[11:9];
   assign o_rs = i_insn[8:6];
   assign o_rt = i_insn[2:0];

   always_comb begin
      // unrecognized words retire as a NOP with a zero result
      o_rs_re = 1'b0;
      o_rt_re = 1'b0;
      o_we    = 1'b0;
      o_op    = lc4_pkg::ALU_PASS;
      o_imm   = '0;
      case (i_insn[15:12])
         lc4_pkg::OPC_ARITH: begin
            if (sub[2]) begin
               // ADD immediate, imm5
               o_rs_re = 1'b1;
               o_we    = 1'b1;
               o_op    = lc4_pkg::ALU_ADD;
               o_imm   = {{11{i_insn[4]}}, i_insn[4:0]};
            end else if (sub == lc4_pkg::SUB_ADD || sub == lc4_pkg::SUB_SUB) begin
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               o_we    = 1'b1;
               o_op    = (sub == lc4_pkg::SUB_SUB) ? lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
            end
         end
         lc4_pkg::OPC_LOGIC: begin
            if (sub == lc4_pkg::SUB_AND || sub == lc4_pkg::SUB_OR ||
                sub == lc4_pkg::SUB_XOR) begin
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               o_we    = 1'b1;
               o_op    = (sub == lc4_pkg::SUB_AND) ? lc4_pkg::ALU_AND :
                         (sub == lc4_pkg::SUB_OR)  ? lc4_pkg::ALU_OR  : lc4_pkg::ALU_XOR;
            end
         end
         lc4_pkg::OPC_CONST: begin
            o_we  = 1'b1;
            o_imm = {{7{i_insn[8]}}, i_insn[8:0]};
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/lc4_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_execute (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire                    i_hold_b,
   input  wire lc4_pkg::word_t    i_pc_a, i_pc_b, i_insn_a, i_insn_b,
   input  wire lc4_pkg::stall_e   i_stall_a, i_stall_b,
   input  wire lc4_pkg::reg_idx_t i_rs_a, i_rt_a, i_rd_a, i_rs_b, i_rt_b, i_rd_b,
   input  wire                    i_rs_re_a, i_rt_re_a, i_we_a,
   input  wire                    i_rs_re_b, i_rt_re_b, i_we_b,
   input  wire lc4_pkg::alu_op_e  i_op_a, i_op_b,
   input  wire lc4_pkg::word_t    i_imm_a, i_imm_b,
   input  wire lc4_pkg::word_t    i_rs_data_a, i_rt_data_a, i_rs_data_b, i_rt_data_b,
   output lc4_pkg::word_t         o_wb_pc_a, o_wb_pc_b, o_wb_insn_a, o_wb_insn_b,
   output logic                   o_wb_we_a, o_wb_we_b,
   output lc4_pkg::reg_idx_t      o_wb_wsel_a, o_wb_wsel_b,
   output lc4_pkg::word_t         o_wb_data_a, o_wb_data_b,
   output lc4_pkg::stall_e        o_wb_stall_a, o_wb_stall_b
);

   lc4_pkg::word_t    x_pc_a, x_pc_b, x_insn_a, x_insn_b, x_imm_a, x_imm_b;
   lc4_pkg::word_t    x_rs_data_a, x_rt_data_a, x_rs_data_b, x_rt_data_b;
   lc4_pkg::word_t    x_opa_a, x_opb_a, x_opa_b, x_opb_b, x_res_a, x_res_b;
   lc4_pkg::reg_idx_t x_rs_a, x_rt_a, x_rd_a, x_rs_b, x_rt_b, x_rd_b;
   logic              x_rs_re_a, x_rt_re_a, x_rs_re_b, x_rt_re_b, x_we_a, x_we_b;
   lc4_pkg::alu_op_e  x_op_a, x_op_b;
   lc4_pkg::stall_e   x_stall_a, x_stall_b;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_stall_a    <= lc4_pkg::STALL_EMPTY;
         x_stall_b    <= lc4_pkg::STALL_EMPTY;
         x_we_a       <= 1'b0;
         x_we_b       <= 1'b0;
         o_wb_stall_a <= lc4_pkg::STALL_EMPTY;
         o_wb_stall_b <= lc4_pkg::STALL_EMPTY;
         o_wb_we_a    <= 1'b0;
         o_wb_we_b    <= 1'b0;
      end else begin
         x_stall_a    <= i_stall_a;
         // held B goes down as a bubble and comes back next cycle in slot A
         x_stall_b    <= i_hold_b ? lc4_pkg::STALL_SS : i_stall_b;
         x_we_a       <= i_we_a;
         x_we_b       <= i_we_b && !i_hold_b;
         o_wb_stall_a <= x_stall_a;
         o_wb_stall_b <= x_stall_b;
         o_wb_we_a    <= x_we_a;
         o_wb_we_b    <= x_we_b;
      end
   end

   always_ff @(posedge gwe) begin
      x_pc_a      <= i_pc_a;
      x_pc_b      <= i_pc_b;
      x_insn_a    <= i_insn_a;
      x_insn_b    <= i_hold_b ? '0 : i_insn_b;
      x_rs_a      <= i_rs_a;
      x_rt_a      <= i_rt_a;
      x_rd_a      <= i_rd_a;
      x_rs_b      <= i_rs_b;
      x_rt_b      <= i_rt_b;
      x_rd_b      <= i_rd_b;
      x_rs_re_a   <= i_rs_re_a;
      x_rt_re_a   <= i_rt_re_a;
      x_rs_re_b   <= i_rs_re_b;
      x_rt_re_b   <= i_rt_re_b;
      x_op_a      <= i_op_a;
      x_op_b      <= i_op_b;
      x_imm_a     <= i_imm_a;
      x_imm_b     <= i_imm_b;
      x_rs_data_a <= i_rs_data_a;
      x_rt_data_a <= i_rt_data_a;
      x_rs_data_b <= i_rs_data_b;
      x_rt_data_b <= i_rt_data_b;
      o_wb_pc_a   <= x_pc_a;
      o_wb_pc_b   <= x_pc_b;
      o_wb_insn_a <= x_insn_a;
      o_wb_insn_b <= x_insn_b;
      o_wb_wsel_a <= x_rd_a;
      o_wb_wsel_b <= x_rd_b;
      o_wb_data_a <= x_res_a;
      o_wb_data_b <= x_res_b;
   end

   // W-to-X bypass, the younger W slot wins
   function automatic lc4_pkg::word_t w_fwd(lc4_pkg::reg_idx_t sel, logic re,
                                            lc4_pkg::word_t rf);
      if (re && o_wb_we_b && o_wb_stall_b == lc4_pkg::STALL_NONE && o_wb_wsel_b == sel)
         return o_wb_data_b;
      if (re && o_wb_we_a && o_wb_stall_a == lc4_pkg::STALL_NONE && o_wb_wsel_a == sel)
         return o_wb_data_a;
      return rf;
   endfunction

   always_comb begin
      x_opa_a = w_fwd(x_rs_a, x_rs_re_a, x_rs_data_a);
      x_opb_a = w_fwd(x_rt_a, x_rt_re_a, x_rt_data_a);
      x_opa_b = w_fwd(x_rs_b, x_rs_re_b, x_rs_data_b);
      x_opb_b = w_fwd(x_rt_b, x_rt_re_b, x_rt_data_b);
   end

   // no rt read means the second operand is the immediate
   lc4_alu alu_a (
      .i_op(x_op_a), .i_a(x_opa_a), .i_b(x_opb_a), .i_imm(x_imm_a),
      .i_use_imm(!x_rt_re_a), .o_result(x_res_a)
   );

   lc4_alu alu_b (
      .i_op(x_op_b), .i_a(x_opa_b), .i_b(x_opb_b), .i_imm(x_imm_b),
      .i_use_imm(!x_rt_re_b), .o_result(x_res_b)
   );

   // the reset bubble leaves both pipes together, so a live B never trails an idle A
   assert property (@(posedge gwe) disable iff (!i_arst_n)
      o_wb_stall_a != lc4_pkg::STALL_NONE |-> o_wb_stall_b != lc4_pkg::STALL_NONE);

endmodule

`default_nettype wire

/* hdl/lc4_fetch_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_fetch_issue (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire lc4_pkg::word_t    i_insn_a, i_insn_b,
   input  wire lc4_pkg::reg_idx_t i_wsel_a,
   input  wire                    i_we_a,
   input  wire lc4_pkg::reg_idx_t i_rs_b, i_rt_b,
   input  wire                    i_rs_re_b, i_rt_re_b,
   output lc4_pkg::word_t         o_pc,
   output lc4_pkg::word_t         o_d_pc_a, o_d_pc_b, o_d_insn_a, o_d_insn_b,
   output lc4_pkg::stall_e        o_d_stall_a, o_d_stall_b,
   output logic                   o_hold_b
);

   // younger slot reads what the older slot writes
   assign o_hold_b = o_d_stall_a != lc4_pkg::STALL_EMPTY && i_we_a &&
                     ((i_rs_re_b && i_rs_b == i_wsel_a) ||
                      (i_rt_re_b && i_rt_b == i_wsel_a));

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_pc        <= lc4_pkg::RESET_PC;
         o_d_insn_a  <= '0;
         o_d_insn_b  <= '0;
         o_d_stall_a <= lc4_pkg::STALL_EMPTY;
         o_d_stall_b <= lc4_pkg::STALL_EMPTY;
      end else if (o_hold_b) begin
         // B slides into slot A, slot B picks up the word at the current PC
         o_pc        <= o_pc + 16'd1;
         o_d_insn_a  <= o_d_insn_b;
         o_d_insn_b  <= i_insn_a;
         o_d_stall_a <= o_d_stall_b;
         o_d_stall_b <= lc4_pkg::STALL_NONE;
      end else begin
         o_pc        <= o_pc + 16'd2;
         o_d_insn_a  <= i_insn_a;
         o_d_insn_b  <= i_insn_b;
         o_d_stall_a <= lc4_pkg::STALL_NONE;
         o_d_stall_b <= lc4_pkg::STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      o_d_pc_a <= o_hold_b ? o_d_pc_b : o_pc;
      o_d_pc_b <= o_hold_b ? o_pc : o_pc + 16'd1;
   end

   // fetch steps by a whole pair, or by one slot when B was held
   assert property (@(posedge gwe) disable iff (!i_arst_n)
      $past(i_arst_n) |-> (o_pc == $past(o_pc) + 16'd1 || o_pc == $past(o_pc) + 16'd2));

endmodule

`default_nettype wire

/* hdl/lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // stall code that follows each slot down to the writeback trace
   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_SS    = 2'd1,
      STALL_EMPTY = 2'd2
   } stall_e;

   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_PASS = 3'd5
   } alu_op_e;

   // major opcode in insn[15:12]
   localparam logic [3:0] OPC_NOP   = 4'd0;
   localparam logic [3:0] OPC_ARITH = 4'd1;
   localparam logic [3:0] OPC_LOGIC = 4'd5;
   localparam logic [3:0] OPC_CONST = 4'd9;

   // sub-opcode in insn[5:3], bit 5 set means immediate form
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   localparam word_t RESET_PC = 16'h8200;
   localparam int    NUM_REGS = 8;

endpackage

`default_nettype wire

/* hdl/lc4_regfile_2w.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_regfile_2w (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   input  wire lc4_pkg::reg_idx_t i_rs_a, i_rt_a, i_rs_b, i_rt_b, i_rd_a, i_rd_b,
   input  wire                    i_we_a, i_we_b,
   input  wire lc4_pkg::word_t    i_wdata_a, i_wdata_b,
   output lc4_pkg::word_t         o_rs_data_a, o_rt_data_a, o_rs_data_b, o_rt_data_b
);

   lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

   // write-to-read bypass, pipe B checked first
   function automatic lc4_pkg::word_t rd_port(lc4_pkg::reg_idx_t sel);
      if (i_we_b && i_rd_b == sel)
         return i_wdata_b;
      if (i_we_a && i_rd_a == sel)
         return i_wdata_a;
      return regs[sel];
   endfunction

   always_comb begin
      o_rs_data_a = rd_port(i_rs_a);
      o_rt_data_a = rd_port(i_rt_a);
      o_rs_data_b = rd_port(i_rs_b);
      o_rt_data_b = rd_port(i_rt_b);
   end

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++)
            regs[i] <= '0;
      end else begin
         if (i_we_a)
            regs[i_rd_a] <= i_wdata_a;
         // B is the younger write, so it lands last
         if (i_we_b)
            regs[i_rd_b] <= i_wdata_b;
      end
   end

endmodule

`default_nettype wire

/* hdl/lc4_superscalar.sv */
`timescale 1ns/10ps
`default_nettype none

module lc4_superscalar (
   input  wire                    gwe,
   input  wire                    i_arst_n,
   output wire lc4_pkg::word_t    o_cur_pc,
   input  wire lc4_pkg::word_t    i_insn_a, i_insn_b,
   output wire lc4_pkg::word_t    o_wb_pc_a, o_wb_pc_b, o_wb_insn_a, o_wb_insn_b,
   output wire                    o_wb_we_a, o_wb_we_b,
   output wire lc4_pkg::reg_idx_t o_wb_wsel_a, o_wb_wsel_b,
   output wire lc4_pkg::word_t    o_wb_data_a, o_wb_data_b,
   output wire lc4_pkg::stall_e   o_wb_stall_a, o_wb_stall_b
);

   // D stage pair
   wire lc4_pkg::word_t    d_pc_a, d_pc_b, d_insn_a, d_insn_b;
   wire lc4_pkg::stall_e   d_stall_a, d_stall_b;
   wire                    d_hold_b;
   // decoded fields per slot
   wire lc4_pkg::reg_idx_t rs_a, rt_a, rd_a, rs_b, rt_b, rd_b;
   wire                    rs_re_a, rt_re_a, we_a, rs_re_b, rt_re_b, we_b;
   wire lc4_pkg::alu_op_e  op_a, op_b;
   wire lc4_pkg::word_t    imm_a, imm_b;
   wire lc4_pkg::word_t    rs_data_a, rt_data_a, rs_data_b, rt_data_b;

   lc4_fetch_issue u_fetch_issue (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_insn_a(i_insn_a), .i_insn_b(i_insn_b),
      .i_wsel_a(rd_a), .i_we_a(we_a), .i_rs_b(rs_b), .i_rt_b(rt_b),
      .i_rs_re_b(rs_re_b), .i_rt_re_b(rt_re_b), .o_pc(o_cur_pc),
      .o_d_pc_a(d_pc_a), .o_d_pc_b(d_pc_b), .o_d_insn_a(d_insn_a), .o_d_insn_b(d_insn_b),
      .o_d_stall_a(d_stall_a), .o_d_stall_b(d_stall_b), .o_hold_b(d_hold_b)
   );

   lc4_decoder decoder_a (
      .i_insn(d_insn_a), .o_rs(rs_a), .o_rt(rt_a), .o_rd(rd_a),
      .o_rs_re(rs_re_a), .o_rt_re(rt_re_a), .o_we(we_a), .o_op(op_a), .o_imm(imm_a)
   );

   lc4_decoder decoder_b (
      .i_insn(d_insn_b), .o_rs(rs_b), .o_rt(rt_b), .o_rd(rd_b),
      .o_rs_re(rs_re_b), .o_rt_re(rt_re_b), .o_we(we_b), .o_op(op_b), .o_imm(imm_b)
   );

   // written from W
   lc4_regfile_2w u_regfile (
      .gwe(gwe), .i_arst_n(i_arst_n),
      .i_rs_a(rs_a), .i_rt_a(rt_a), .i_rs_b(rs_b), .i_rt_b(rt_b),
      .i_rd_a(o_wb_wsel_a), .i_rd_b(o_wb_wsel_b), .i_we_a(o_wb_we_a), .i_we_b(o_wb_we_b),
      .i_wdata_a(o_wb_data_a), .i_wdata_b(o_wb_data_b),
      .o_rs_data_a(rs_data_a), .o_rt_data_a(rt_data_a),
      .o_rs_data_b(rs_data_b), .o_rt_data_b(rt_data_b)
   );

   lc4_execute u_execute (
      .gwe(gwe), .i_arst_n(i_arst_n), .i_hold_b(d_hold_b),
      .i_pc_a(d_pc_a), .i_pc_b(d_pc_b), .i_insn_a(d_insn_a), .i_insn_b(d_insn_b),
      .i_stall_a(d_stall_a), .i_stall_b(d_stall_b),
      .i_rs_a(rs_a), .i_rt_a(rt_a), .i_rd_a(rd_a), .i_rs_b(rs_b), .i_rt_b(rt_b), .i_rd_b(rd_b),
      .i_rs_re_a(rs_re_a), .i_rt_re_a(rt_re_a), .i_we_a(we_a),
      .i_rs_re_b(rs_re_b), .i_rt_re_b(rt_re_b), .i_we_b(we_b),
      .i_op_a(op_a), .i_op_b(op_b), .i_imm_a(imm_a), .i_imm_b(imm_b),
      .i_rs_data_a(rs_data_a), .i_rt_data_a(rt_data_a),
      .i_rs_data_b(rs_data_b), .i_rt_data_b(rt_data_b),
      .o_wb_pc_a(o_wb_pc_a), .o_wb_pc_b(o_wb_pc_b),
      .o_wb_insn_a(o_wb_insn_a), .o_wb_insn_b(o_wb_insn_b),
      .o_wb_we_a(o_wb_we_a), .o_wb_we_b(o_wb_we_b),
      .o_wb_wsel_a(o_wb_wsel_a), .o_wb_wsel_b(o_wb_wsel_b),
      .o_wb_data_a(o_wb_data_a), .o_wb_data_b(o_wb_data_b),
      .o_wb_stall_a(o_wb_stall_a), .o_wb_stall_b(o_wb_stall_b)
   );

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hdl/lc4_pkg.sv
hdl/lc4_alu.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile_2w.sv
hdl/lc4_fetch_issue.sv
hdl/lc4_execute.sv
hdl/lc4_superscalar.sv
bench/tb_lc4_superscalar.sv
